//--- link_mon_settings.svh
// counter width must stay above the credits field width or the credit sum saturates per packet
`ifndef LINK_MON_SETTINGS_SVH
`define LINK_MON_SETTINGS_SVH

// ======================================================================
// counter bank
// ======================================================================

// width of every performance counter
`define LINK_MON_CNT_W 32

// cycles, tx valid, rx valid, credit packets, credit sum, stalls
`define LINK_MON_NUM_CNT 6

// ======================================================================
// link side
// ======================================================================

// one link header word
`define LINK_MON_HDR_W 16

// narrow request, narrow response, wide
`define LINK_MON_NUM_CHAN 3

`endif

//--- link_pkt_pkg.sv
// header layout assumes the credits_only flag is the top bit in both views; widths come from the header width macro
`include "link_mon_settings.svh"

package link_pkt_pkg;

  // ======================================================================
  // field widths derived from the header width
  // ======================================================================

  // flag + 2 bit channel id + payload length
  localparam int unsigned PAYLOAD_LEN_W = `LINK_MON_HDR_W - 3;

  // flag + 3 reserved bits + credits
  localparam int unsigned CREDITS_W = `LINK_MON_HDR_W - 4;

  typedef logic [CREDITS_W-1:0] credits_t;

  // ======================================================================
  // header views
  // ======================================================================

  // normal data packet with credits_only at 0
  typedef struct packed {
    logic                     credits_only;
    logic [1:0]               chan_id;
    logic [PAYLOAD_LEN_W-1:0] payload_len;
  } link_data_hdr_t;

  // credit-only packet with credits_only at 1
  typedef struct packed {
    logic       credits_only;
    logic [2:0] reserved;
    credits_t   credits;
  } link_cred_hdr_t;

  // top bit of the shared word selects the view
  typedef union packed {
    link_data_hdr_t data;
    link_cred_hdr_t cred;
  } link_hdr_u;

endpackage

//--- link_mon_pkg.sv
// counter order is fixed by the enum values; the readout select uses the same encoding
`include "link_mon_settings.svh"

package link_mon_pkg;

  // ======================================================================
  // counter indices
  // ======================================================================

  typedef enum logic [2:0] {
    CNT_CYCLES    = 3'd0,
    CNT_TX_VALID  = 3'd1,
    CNT_RX_VALID  = 3'd2,
    CNT_CRED_PKTS = 3'd3,
    CNT_CRED_SUM  = 3'd4,
    CNT_STALL     = 3'd5
  } cnt_idx_e;

  typedef logic [`LINK_MON_CNT_W-1:0] cnt_t;

  // whole bank, indexed by cnt_idx_e
  typedef cnt_t [`LINK_MON_NUM_CNT-1:0] cnt_vec_t;

  // ======================================================================
  // decoded event record, one per cycle
  // ======================================================================

  typedef struct packed {
    logic                  tick;
    logic                  tx_valid;
    logic                  rx_valid;
    logic                  cred_pkt;
    logic                  stall;
    // zero unless cred_pkt is set
    link_pkt_pkg::credits_t cred_amount;
    logic                  clear;
    logic                  spare;
  } link_event_t;

endpackage

//--- link_event_decode.sv
// raw inputs register at edge N and the event record at N+1; all inputs are plain levels
`timescale 1ns/1ps
`include "link_mon_settings.svh"

module link_event_decode (
  input  logic                              i_serial_link_0,
  input  logic                              i_reset,
  input  logic                              i_tx_valid,
  input  logic                              i_tx_ready,
  input  link_pkt_pkg::link_hdr_u           i_tx_hdr,
  input  logic                              i_rx_valid,
  input  logic [`LINK_MON_NUM_CHAN-1:0]     i_chan_valid,
  input  logic [`LINK_MON_NUM_CHAN-1:0]     i_chan_credit_ok,
  input  logic                              i_clear,
  output link_mon_pkg::link_event_t         o_ev
);

  // ======================================================================
  // input sampling
  // ======================================================================

  logic                          tick_q;
  logic                          tx_valid_q;
  logic                          tx_ready_q;
  logic                          rx_valid_q;
  logic                          clear_q;
  logic [`LINK_MON_NUM_CHAN-1:0] chan_valid_q;
  logic [`LINK_MON_NUM_CHAN-1:0] chan_credit_ok_q;
  link_pkt_pkg::link_hdr_u       hdr_q;

  always_ff @(posedge i_serial_link_0) begin
    if (i_reset) begin
      tick_q           <= 1'b0;
      tx_valid_q       <= 1'b0;
      tx_ready_q       <= 1'b0;
      rx_valid_q       <= 1'b0;
      clear_q          <= 1'b0;
      chan_valid_q     <= '0;
      chan_credit_ok_q <= '0;
    end else begin
      // high in every cycle once out of reset
      tick_q           <= 1'b1;
      tx_valid_q       <= i_tx_valid;
      tx_ready_q       <= i_tx_ready;
      rx_valid_q       <= i_rx_valid;
      clear_q          <= i_clear;
      chan_valid_q     <= i_chan_valid;
      chan_credit_ok_q <= i_chan_credit_ok;
    end
  end

  // raw header word, only read through cred_pkt
  always_ff @(posedge i_serial_link_0) begin
    hdr_q <= i_tx_hdr;
  end

  // ======================================================================
  // decode
  // ======================================================================

  logic                      is_cred_hdr;
  logic                      cred_pkt;
  logic                      stall;
  link_mon_pkg::link_event_t ev_d;

  // top bit is shared by both views
  assign is_cred_hdr = hdr_q.cred.credits_only;

  // only a completed tx handshake counts as a sent packet
  assign cred_pkt = tx_valid_q & tx_ready_q & is_cred_hdr;

  // several channels stalling at once still count as one cycle
  assign stall = |(chan_valid_q & ~chan_credit_ok_q);

  always_comb begin
    ev_d             = '0;
    ev_d.tick        = tick_q;
    ev_d.tx_valid    = tx_valid_q;
    ev_d.rx_valid    = rx_valid_q;
    ev_d.cred_pkt    = cred_pkt;
    ev_d.stall       = stall;
    ev_d.cred_amount = cred_pkt ? hdr_q.cred.credits : '0;
    ev_d.clear       = clear_q;
    ev_d.spare       = 1'b0;
  end

  // event record register
  always_ff @(posedge i_serial_link_0) begin
    if (i_reset) begin
      o_ev <= '0;
    end else begin
      o_ev <= ev_d;
    end
  end

endmodule

//--- link_counter_bank.sv
// counters saturate at all ones and never wrap; clear in the event record beats every event
`timescale 1ns/1ps
`include "link_mon_settings.svh"

module link_counter_bank (
  input  logic                      i_serial_link_0,
  input  logic                      i_reset,
  input  link_mon_pkg::link_event_t i_ev,
  output link_mon_pkg::cnt_vec_t    o_cnt_vec
);

  // ======================================================================
  // step per counter
  // ======================================================================

  link_mon_pkg::cnt_vec_t step;
  link_mon_pkg::cnt_vec_t cnt_q;
  link_mon_pkg::cnt_vec_t cnt_d;

  // five counters step by one, the credit sum by the credit amount
  always_comb begin
    step                              = '0;
    step[link_mon_pkg::CNT_CYCLES]    = link_mon_pkg::cnt_t'(i_ev.tick);
    step[link_mon_pkg::CNT_TX_VALID]  = link_mon_pkg::cnt_t'(i_ev.tx_valid);
    step[link_mon_pkg::CNT_RX_VALID]  = link_mon_pkg::cnt_t'(i_ev.rx_valid);
    step[link_mon_pkg::CNT_CRED_PKTS] = link_mon_pkg::cnt_t'(i_ev.cred_pkt);
    step[link_mon_pkg::CNT_CRED_SUM]  = link_mon_pkg::cnt_t'(i_ev.cred_amount);
    step[link_mon_pkg::CNT_STALL]     = link_mon_pkg::cnt_t'(i_ev.stall);
  end

  // ======================================================================
  // saturating add
  // ======================================================================

  always_comb begin : sat_add
    logic [`LINK_MON_CNT_W:0] sum;
    cnt_d = cnt_q;
    for (int i = 0; i < `LINK_MON_NUM_CNT; i++) begin
      sum = {1'b0, cnt_q[i]} + {1'b0, step[i]};
      // carry out means the counter clamps at its maximum
      if (sum[`LINK_MON_CNT_W]) begin
        cnt_d[i] = '1;
      end else begin
        cnt_d[i] = sum[`LINK_MON_CNT_W-1:0];
      end
    end
  end

  always_ff @(posedge i_serial_link_0) begin
    if (i_reset) begin
      cnt_q <= '0;
    end else if (i_ev.clear) begin
      // events of the clear cycle are dropped
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign o_cnt_vec = cnt_q;

endmodule

//--- link_counter_readout.sv
// read data lags the select by one cycle; the saturation flag is sticky and only reset clears it
`timescale 1ns/1ps
`include "link_mon_settings.svh"

module link_counter_readout (
  input  logic                   i_serial_link_0,
  input  logic                   i_reset,
  input  link_mon_pkg::cnt_vec_t i_cnt_vec,
  input  link_mon_pkg::cnt_idx_e i_rd_sel,
  output link_mon_pkg::cnt_t     o_rd_data,
  output logic                   o_saturated
);

  // ======================================================================
  // read mux
  // ======================================================================

  link_mon_pkg::cnt_t rd_data_d;

  // unused select codes read as zero
  always_comb begin
    if (int'(i_rd_sel) < `LINK_MON_NUM_CNT) begin
      rd_data_d = i_cnt_vec[i_rd_sel];
    end else begin
      rd_data_d = '0;
    end
  end

  always_ff @(posedge i_serial_link_0) begin
    if (i_reset) begin
      o_rd_data <= '0;
    end else begin
      o_rd_data <= rd_data_d;
    end
  end

  // ======================================================================
  // saturation detect
  // ======================================================================

  logic [`LINK_MON_NUM_CNT-1:0] at_max;

  always_comb begin
    for (int i = 0; i < `LINK_MON_NUM_CNT; i++) begin
      at_max[i] = &i_cnt_vec[i];
    end
  end

  // survives clear pulses on purpose
  always_ff @(posedge i_serial_link_0) begin
    if (i_reset) begin
      o_saturated <= 1'b0;
    end else begin
      o_saturated <= o_saturated | (|at_max);
    end
  end

endmodule

//--- link_perf_monitor.sv
// single clock domain on i_serial_link_0; no handshake, every cycle is sampled and counted
`timescale 1ns/1ps
`include "link_mon_settings.svh"

module link_perf_monitor (
  input  logic                          i_serial_link_0,
  input  logic                          i_reset,
  input  logic                          i_tx_valid,
  input  logic                          i_tx_ready,
  input  link_pkt_pkg::link_hdr_u       i_tx_hdr,
  input  logic                          i_rx_valid,
  input  logic [`LINK_MON_NUM_CHAN-1:0] i_chan_valid,
  input  logic [`LINK_MON_NUM_CHAN-1:0] i_chan_credit_ok,
  input  logic                          i_clear,
  input  link_mon_pkg::cnt_idx_e        i_rd_sel,
  output logic [`LINK_MON_CNT_W-1:0]    o_rd_data,
  output logic                          o_saturated
);

  link_mon_pkg::link_event_t ev;
  link_mon_pkg::cnt_vec_t    cnt_vec;

  // decode stage
  link_event_decode u_decode (
    .i_serial_link_0  (i_serial_link_0),
    .i_reset          (i_reset),
    .i_tx_valid       (i_tx_valid),
    .i_tx_ready       (i_tx_ready),
    .i_tx_hdr         (i_tx_hdr),
    .i_rx_valid       (i_rx_valid),
    .i_chan_valid     (i_chan_valid),
    .i_chan_credit_ok (i_chan_credit_ok),
    .i_clear          (i_clear),
    .o_ev             (ev)
  );

  // execute stage
  link_counter_bank u_bank (
    .i_serial_link_0 (i_serial_link_0),
    .i_reset         (i_reset),
    .i_ev            (ev),
    .o_cnt_vec       (cnt_vec)
  );

  // result stage
  link_counter_readout u_readout (
    .i_serial_link_0 (i_serial_link_0),
    .i_reset         (i_reset),
    .i_cnt_vec       (cnt_vec),
    .i_rd_sel        (i_rd_sel),
    .o_rd_data       (o_rd_data),
    .o_saturated     (o_saturated)
  );

endmodule

//--- link_perf_monitor_asserts.sv
// bound to link_perf_monitor; relies on its internal ev and cnt_vec nets keeping their names
`timescale 1ns/1ps
`include "link_mon_settings.svh"

module link_perf_monitor_asserts (
  input logic                       i_serial_link_0,
  input logic                       i_reset,
  input link_mon_pkg::link_event_t  ev,
  input link_mon_pkg::cnt_vec_t     cnt_vec,
  input logic [`LINK_MON_CNT_W-1:0] o_rd_data,
  input logic                       o_saturated
);

  // read data register leaves reset at zero
  rd_data_after_reset: assert property (
    @(posedge i_serial_link_0) i_reset |=> (o_rd_data == '0)
  ) else $error("read data is not zero one cycle after reset");

  // saturation flag is sticky outside reset
  saturated_sticky: assert property (
    @(posedge i_serial_link_0) disable iff (i_reset)
      o_saturated |=> o_saturated
  ) else $error("saturation flag dropped while out of reset");

  // clear in the event record zeroes the bank on the next edge
  clear_zeroes_bank: assert property (
    @(posedge i_serial_link_0) disable iff (i_reset)
      ev.clear |=> (cnt_vec[link_mon_pkg::CNT_CYCLES] < 3)
  ) else $error("cycle counter not near zero after a clear");

endmodule

bind link_perf_monitor link_perf_monitor_asserts u_asserts (
  .i_serial_link_0 (i_serial_link_0),
  .i_reset         (i_reset),
  .ev              (ev),
  .cnt_vec         (cnt_vec),
  .o_rd_data       (o_rd_data),
  .o_saturated     (o_saturated)
);

//--- tb_link_perf_monitor.sv
// phases run in table order on one shared model; the saturation phase alone takes ~1M link cycles
`timescale 1ns/1ps
`include "link_mon_settings.svh"

module tb_link_perf_monitor;

  localparam int NUM_PHASES  = 8;
  localparam int RD_TIMEOUT  = 8;
  localparam int IDLE_CYCLES = 3;

  // one cycle of driven link activity
  typedef struct packed {
    logic        tx_valid;
    logic        tx_ready;
    logic        cred_kind;
    logic [11:0] credits;
    logic        rx_valid;
    logic [2:0]  chan_valid;
    logic [2:0]  credit_ok;
    logic        clear;
  } stim_t;

  typedef struct packed {
    logic [31:0] len;
    stim_t       fix;
    // one random flag per field in order tx_valid tx_ready kind credits rx_valid chan_valid credit_ok
    logic [6:0]  rnd;
    // cycle of the phase with a clear pulse or all ones for none
    logic [31:0] clr_at;
  } phase_t;

  localparam stim_t IDLE = '0;

  logic                          i_serial_link_0;
  logic                          i_reset;
  logic                          i_tx_valid;
  logic                          i_tx_ready;
  link_pkt_pkg::link_hdr_u       i_tx_hdr;
  logic                          i_rx_valid;
  logic [`LINK_MON_NUM_CHAN-1:0] i_chan_valid;
  logic [`LINK_MON_NUM_CHAN-1:0] i_chan_credit_ok;
  logic                          i_clear;
  link_mon_pkg::cnt_idx_e        i_rd_sel;
  logic [`LINK_MON_CNT_W-1:0]    o_rd_data;
  logic                          o_saturated;

  // reference model and what was seen at the last falling edge
  link_mon_pkg::cnt_vec_t model;
  link_mon_pkg::cnt_vec_t hist_q[$];
  link_mon_pkg::cnt_vec_t rd_vals;
  logic                   exp_sat;
  logic [15:0]            lfsr;
  logic [2:0]             cur_sel;
  logic [2:0]             seen_sel;
  logic [31:0]            seen_data;
  logic [31:0]            exp_data;
  logic                   seen_sat;
  int                     errors;
  int                     tests;
  int                     passed;
  int                     failed;

  phase_t                 phase_tab[NUM_PHASES];
  string                  phase_name[NUM_PHASES];
  link_mon_pkg::cnt_vec_t delta_tab[NUM_PHASES];

  link_perf_monitor uut (
    .i_serial_link_0  (i_serial_link_0),
    .i_reset          (i_reset),
    .i_tx_valid       (i_tx_valid),
    .i_tx_ready       (i_tx_ready),
    .i_tx_hdr         (i_tx_hdr),
    .i_rx_valid       (i_rx_valid),
    .i_chan_valid     (i_chan_valid),
    .i_chan_credit_ok (i_chan_credit_ok),
    .i_clear          (i_clear),
    .i_rd_sel         (i_rd_sel),
    .o_rd_data        (o_rd_data),
    .o_saturated      (o_saturated)
  );

  // first falling edge at 50 ns
  initial i_serial_link_0 = 1'b1;
  always #50 i_serial_link_0 = ~i_serial_link_0;

  // ======================================================================
  // random bits and reference model
  // ======================================================================

  // 16 bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [11:0] rand_bits(input int n);
    logic [11:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[10:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] sat_add(input logic [31:0] a, input logic [31:0] b);
    logic [32:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[32] ? 32'hFFFF_FFFF : s[31:0];
  endfunction

  function automatic void bump(input int idx, input logic [31:0] amt);
    model[idx] = sat_add(model[idx], amt);
  endfunction

  function automatic void update_model(input stim_t s, input logic rst);
    if (rst) begin
      model   = '0;
      exp_sat = 1'b0;
    end else if (s.clear) begin
      // events of the clear cycle are lost
      model = '0;
    end else begin
      bump(link_mon_pkg::CNT_CYCLES, 32'd1);
      bump(link_mon_pkg::CNT_TX_VALID, {31'd0, s.tx_valid});
      bump(link_mon_pkg::CNT_RX_VALID, {31'd0, s.rx_valid});
      if (s.tx_valid && s.tx_ready && s.cred_kind) begin
        bump(link_mon_pkg::CNT_CRED_PKTS, 32'd1);
        bump(link_mon_pkg::CNT_CRED_SUM, {20'd0, s.credits});
      end
      if (|(s.chan_valid & ~s.credit_ok)) begin
        bump(link_mon_pkg::CNT_STALL, 32'd1);
      end
    end
    for (int i = 0; i < `LINK_MON_NUM_CNT; i++) begin
      if (&model[i]) begin
        exp_sat = 1'b1;
      end
    end
  endfunction

  function automatic stim_t make_stim(input logic tx_v, input logic tx_r, input logic kind,
                                      input logic [11:0] cred, input logic rx_v,
                                      input logic [2:0] cv, input logic [2:0] ok);
    return {tx_v, tx_r, kind, cred, rx_v, cv, ok, 1'b0};
  endfunction

  // ======================================================================
  // drive, read and check
  // ======================================================================

  task automatic step(input stim_t s, input logic rst, input logic [2:0] sel);
    logic [15:0] hdr_word;
    @(negedge i_serial_link_0);
    // read data now shows the select and counts of three samples back
    seen_data = o_rd_data;
    seen_sat  = o_saturated;
    seen_sel  = cur_sel;
    exp_data  = hist_q[0][cur_sel];
    if (s.cred_kind) begin
      hdr_word = {1'b1, 3'b000, s.credits};
    end else begin
      // data header with payload_len of 4096 or more
      hdr_word = {1'b0, 2'b10, 1'b1, s.credits};
    end
    i_reset          = rst;
    i_tx_valid       = s.tx_valid;
    i_tx_ready       = s.tx_ready;
    i_tx_hdr         = hdr_word;
    i_rx_valid       = s.rx_valid;
    i_chan_valid     = s.chan_valid;
    i_chan_credit_ok = s.credit_ok;
    i_clear          = s.clear;
    i_rd_sel         = link_mon_pkg::cnt_idx_e'(sel);
    cur_sel          = sel;
    update_model(s, rst);
    hist_q.push_back(model);
    hist_q.delete(0);
  endtask

  task automatic read_counter(input int sel, output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < RD_TIMEOUT) begin
      step(IDLE, 1'b0, sel[2:0]);
      if (seen_sel == sel[2:0] && seen_data == exp_data) begin
        ok = 1'b1;
      end
      n++;
    end
    rd_vals[sel] = seen_data;
    if (!ok) begin
      $display("mismatch at %0t: counter %0d expected %0d, read %0d after %0d cycles",
               $time, sel, exp_data, seen_data, RD_TIMEOUT);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      passed++;
      $display("test %0d %s: pass", tests, name);
    end else begin
      failed++;
      $display("test %0d %s: fail with %0d errors", tests, name, errors - err_before);
    end
  endtask

  task automatic set_phase(input int idx, input string name, input int len,
                           input stim_t fix, input logic [6:0] rnd, input int clr_at);
    phase_name[idx]       = name;
    phase_tab[idx].len    = len;
    phase_tab[idx].fix    = fix;
    phase_tab[idx].rnd    = rnd;
    phase_tab[idx].clr_at = clr_at;
  endtask

  task automatic run_phase(input int p);
    phase_t                 ph;
    stim_t                  s;
    link_mon_pkg::cnt_vec_t start;
    link_mon_pkg::cnt_vec_t prev;
    int                     err0;
    logic                   ok;
    ph    = phase_tab[p];
    start = model;
    prev  = rd_vals;
    err0  = errors;
    for (int c = 0; c < ph.len; c++) begin
      s = ph.fix;
      if (ph.rnd[6]) s.tx_valid = lfsr_bit();
      if (ph.rnd[5]) s.tx_ready = lfsr_bit();
      if (ph.rnd[4]) s.cred_kind = lfsr_bit();
      if (ph.rnd[3]) s.credits = rand_bits(12);
      if (ph.rnd[2]) s.rx_valid = lfsr_bit();
      if (ph.rnd[1]) s.chan_valid = 3'(rand_bits(3));
      if (ph.rnd[0]) s.credit_ok = 3'(rand_bits(3));
      s.clear = (c == ph.clr_at);
      step(s, 1'b0, 3'd0);
    end
    for (int i = 0; i < `LINK_MON_NUM_CNT; i++) begin
      delta_tab[p][i] = model[i] - start[i];
    end
    repeat (IDLE_CYCLES) step(IDLE, 1'b0, 3'd0);
    for (int sel = 0; sel < `LINK_MON_NUM_CNT; sel++) begin
      read_counter(sel, ok);
    end
    if (seen_sat !== exp_sat) begin
      $display("mismatch at %0t: o_saturated is %0b, expected %0b", $time, seen_sat, exp_sat);
      errors++;
    end
    // idle and read cycles move only the cycle counter
    if (&ph.clr_at) begin
      for (int i = 1; i < `LINK_MON_NUM_CNT; i++) begin
        if (rd_vals[i] - prev[i] != delta_tab[p][i]) begin
          $display("mismatch at %0t: counter %0d moved by %0d in the phase, expected %0d",
                   $time, i, rd_vals[i] - prev[i], delta_tab[p][i]);
          errors++;
        end
      end
    end
    finish_test(phase_name[p], err0);
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================

  initial begin : main
    logic        ok;
    logic [31:0] first;
    int          err0;
    i_reset          = 1'b1;
    i_tx_valid       = 1'b0;
    i_tx_ready       = 1'b0;
    i_tx_hdr         = '0;
    i_rx_valid       = 1'b0;
    i_chan_valid     = '0;
    i_chan_credit_ok = '0;
    i_clear          = 1'b0;
    i_rd_sel         = link_mon_pkg::CNT_CYCLES;
    lfsr     = 16'd78;
    model    = '0;
    rd_vals  = '0;
    exp_sat  = 1'b0;
    cur_sel  = 3'd0;
    errors   = 0;
    tests    = 0;
    passed   = 0;
    failed   = 0;
    repeat (4) hist_q.push_back('0);

    set_phase(0, "idle after reset", 4, IDLE, 7'b0000000, -1);
    set_phase(1, "tx and rx valid", 64, IDLE, 7'b1100100, -1);
    set_phase(2, "credit packets", 64, IDLE, 7'b1111000, -1);
    set_phase(3, "channel stalls", 64, IDLE, 7'b0000011, -1);
    set_phase(4, "clear mid phase", 32, IDLE, 7'b1111111, 16);
    set_phase(5, "clear drops same cycle", 16,
              make_stim(1'b1, 1'b1, 1'b1, 12'hABC, 1'b1, 3'b111, 3'b000), 7'b0, 15);
    set_phase(6, "credit sum saturation", 1049000,
              make_stim(1'b1, 1'b1, 1'b1, 12'hFFF, 1'b0, 3'b000, 3'b111), 7'b0, -1);
    set_phase(7, "clear after saturation", 2, IDLE, 7'b0, 0);

    step(IDLE, 1'b1, 3'd0);
    step(IDLE, 1'b1, 3'd0);

    // nothing reaches read data until three samples after reset
    err0 = errors;
    for (int c = 0; c < 4; c++) begin
      step(IDLE, 1'b0, c[2:0]);
      if (seen_data !== '0 || seen_sat !== 1'b0) begin
        $display("mismatch at %0t: read %0d, saturated %0b after reset, expected zero",
                 $time, seen_data, seen_sat);
        errors++;
      end
    end
    finish_test("reset state", err0);

    for (int p = 0; p < NUM_PHASES; p++) begin
      run_phase(p);
      if (p == 0) begin
        err0 = errors;
        read_counter(0, ok);
        first = seen_data;
        repeat (5) step(IDLE, 1'b0, 3'd0);
        if (seen_data != first + 32'd5) begin
          $display("mismatch at %0t: cycle counter went from %0d to %0d in 5 cycles",
                   $time, first, seen_data);
          errors++;
        end
        finish_test("cycle count growth", err0);
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests, passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
link_pkt_pkg.sv
link_mon_pkg.sv
link_event_decode.sv
link_counter_bank.sv
link_counter_readout.sv
link_perf_monitor.sv
link_perf_monitor_asserts.sv
tb_link_perf_monitor.sv

//--- Bender.yml
package:
  name: link_perf_monitor

export_include_dirs:
  - .

sources:
  # RTL in compile order
  - link_pkt_pkg.sv
  - link_mon_pkg.sv
  - link_event_decode.sv
  - link_counter_bank.sv
  - link_counter_readout.sv
  - link_perf_monitor.sv

  # testbench and bound assertions
  - target: test
    files:
      - link_perf_monitor_asserts.sv
      - tb_link_perf_monitor.sv
